// File: logic/xotr_pkg.sv
/* Shared constants and opcode type for the
   extended-opcode (ED table) decode stage. */
package xotr_pkg;

    // ********************
    // Timing steps
    // ********************
    localparam int xpt_steps  = 5;   // Width of the xpt one-hot.
    localparam int ld_step    = 0;
    localparam int alu16_step = 1;
    localparam int io_step    = 2;

    // Field codes of the groups handled here.
    localparam logic [1:0] x_group   = 2'd1;   // 01xxxxxx block.
    localparam logic [2:0] z_ld_pair = 3'd3;
    localparam logic [2:0] z_alu16   = 3'd2;
    localparam logic [2:0] z_in      = 3'd0;
    localparam logic [2:0] z_out     = 3'd1;

    // ********************
    // Register codes
    // ********************
    localparam logic [1:0] pair_bc = 2'd0;
    localparam logic [1:0] pair_de = 2'd1;
    localparam logic [1:0] pair_hl = 2'd2;
    localparam logic [1:0] pair_sp = 2'd3;

    localparam logic [2:0] reg_b = 3'd0;
    localparam logic [2:0] reg_c = 3'd1;
    localparam logic [2:0] reg_d = 3'd2;
    localparam logic [2:0] reg_e = 3'd3;
    localparam logic [2:0] reg_h = 3'd4;
    localparam logic [2:0] reg_l = 3'd5;
    localparam logic [2:0] reg_f = 3'd6;   // Flags-only IN, zero OUT.
    localparam logic [2:0] reg_a = 3'd7;

    // Second opcode byte split as x:p:q:z, y being {p, q}.
    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;
        logic       q;
        logic [2:0] z;
    } opcode_fields_t;

    // Raw byte as latched, or decoded by fields.
    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_t;

endpackage

// File: logic/xotr_bus_if.sv
`timescale 1ns/1ps
/* Sequencer state shared with the group decoders. */
interface xotr_bus_if import xotr_pkg::*; (
    input logic clk
);

    // ********************
    // Sequencer state
    // ********************
    logic                 xotr;     // Extended table active.
    logic [xpt_steps-1:0] xpt;      // One-hot timing step.
    opcode_t              source;   // Latched second byte.

    // Sequencer side drives the state.
    modport seq (
        output xotr,
        output xpt,
        output source
    );

    // Decoders only look at it.
    modport dec (
        input clk,
        input xotr,
        input xpt,
        input source
    );

endinterface

// File: logic/xotr_sequencer.sv
`timescale 1ns/1ps
/* Extended-opcode sequencer. Latches the ED byte, steps xpt
   and clears on a decoder request or when the last step runs out. */
module xotr_sequencer import xotr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ir_load,
    input  logic       ed_prefix,
    input  logic [7:0] ir,
    input  logic       ld_done,
    input  logic       alu16_done,
    input  logic       io_done,
    xotr_bus_if.seq    bus,
    output logic       busy,
    output logic       xotr_abort
);

    logic start;
    logic any_done;
    logic last_step;

    // Loads while busy are dropped.
    assign start     = ir_load & ed_prefix & ~bus.xotr;
    assign any_done  = ld_done | alu16_done | io_done;
    assign last_step = bus.xpt[xpt_steps-1];

    // ********************
    // Step control
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.xotr <= 1'b0;
            bus.xpt  <= '0;
        end else if (start) begin
            bus.xotr <= 1'b1;
            bus.xpt  <= {{(xpt_steps-1){1'b0}}, 1'b1};   // Step 0.
        end else if (bus.xotr) begin
            if (any_done || last_step) begin
                // Claimed, or nobody wanted it.
                bus.xotr <= 1'b0;
                bus.xpt  <= '0;
            end else begin
                bus.xpt <= bus.xpt << 1;
            end
        end
    end

    // Opcode register.
    always_ff @(posedge clk) begin
        if (start) begin
            bus.source.raw <= ir;
        end
    end

    // ********************
    // Status
    // ********************
    assign busy = bus.xotr;

    // Last step passing unclaimed.
    assign xotr_abort = last_step & ~any_done;

    // ********************
    // Checks
    // ********************
    a_xpt_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bus.xpt)
    ) else $error("xpt not one-hot: %h", bus.xpt);

    a_xpt_xotr: assert property (
        @(posedge clk) disable iff (reset)
        (bus.xpt != '0) == bus.xotr
    ) else $error("xpt %h does not track xotr %b", bus.xpt, bus.xotr);

    // Each group owns its own step, so requests never overlap.
    a_one_done: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({ld_done, alu16_done, io_done})
    ) else $error("more than one decoder done in one cycle");

endmodule

// File: logic/xotr_ld_nn_dd_decoder.sv
`timescale 1ns/1ps
/* Group 01ddq011 decoder, LD (nn),dd and LD dd,(nn). */
module xotr_ld_nn_dd_decoder import xotr_pkg::*; (
    xotr_bus_if.dec    bus,
    output logic       done,
    output logic       set_cmr,
    output logic [3:0] ld_nn_dd,
    output logic [3:0] ld_dd_nn
);

    logic       hit;
    logic [3:0] pair_hot;

    // Only looked at in its own step.
    assign hit = bus.xpt[ld_step]
               && (bus.source.f.x == x_group)
               && (bus.source.f.z == z_ld_pair);

    // ********************
    // Pair select
    // ********************
    always_comb begin
        pair_hot = '0;
        case (bus.source.f.p)
            pair_bc: pair_hot[pair_bc] = 1'b1;
            pair_de: pair_hot[pair_de] = 1'b1;
            pair_hl: pair_hot[pair_hl] = 1'b1;
            pair_sp: pair_hot[pair_sp] = 1'b1;
            default: pair_hot = '0;
        endcase
    end

    // q low stores the pair, q high loads it.
    assign ld_nn_dd = (hit && !bus.source.f.q) ? pair_hot : '0;
    assign ld_dd_nn = (hit &&  bus.source.f.q) ? pair_hot : '0;

    assign set_cmr = hit;   // Fetch nn next.
    assign done    = hit;   // Clears xpt and xotr.

    // ********************
    // Checks
    // ********************
    a_quiet_idle: assert property (
        @(posedge bus.clk)
        !bus.xotr |-> (!done && !set_cmr && (ld_nn_dd == '0) && (ld_dd_nn == '0))
    ) else $error("ld decoder active while xotr low");

endmodule

// File: logic/xotr_alu16_decoder.sv
`timescale 1ns/1ps
/* Group 01ssq010 decoder, SBC HL,ss and ADC HL,ss. */
module xotr_alu16_decoder import xotr_pkg::*; (
    xotr_bus_if.dec    bus,
    output logic       done,
    output logic [3:0] adc_hl,
    output logic [3:0] sbc_hl
);

    logic       hit;
    logic [3:0] pair_hot;

    assign hit = bus.xpt[alu16_step]
               && (bus.source.f.x == x_group)
               && (bus.source.f.z == z_alu16);

    // ********************
    // Pair select
    // ********************
    always_comb begin
        pair_hot = '0;
        case (bus.source.f.p)
            pair_bc: pair_hot[pair_bc] = 1'b1;
            pair_de: pair_hot[pair_de] = 1'b1;
            pair_hl: pair_hot[pair_hl] = 1'b1;
            pair_sp: pair_hot[pair_sp] = 1'b1;
            default: pair_hot = '0;
        endcase
    end

    // q low is SBC, q high is ADC.
    assign sbc_hl = (hit && !bus.source.f.q) ? pair_hot : '0;
    assign adc_hl = (hit &&  bus.source.f.q) ? pair_hot : '0;

    assign done = hit;

endmodule

// File: logic/xotr_io_decoder.sv
`timescale 1ns/1ps
/* Group 01rrr00d decoder, IN r,(C) and OUT (C),r. */
module xotr_io_decoder import xotr_pkg::*; (
    xotr_bus_if.dec    bus,
    output logic       done,
    output logic [7:0] in_r,
    output logic [7:0] out_r
);

    logic       in_hit;
    logic       out_hit;
    logic [2:0] y;
    logic [7:0] reg_hot;

    assign y = {bus.source.f.p, bus.source.f.q};

    // z picks the direction.
    assign in_hit  = bus.xpt[io_step] && (bus.source.f.x == x_group)
                     && (bus.source.f.z == z_in);
    assign out_hit = bus.xpt[io_step] && (bus.source.f.x == x_group)
                     && (bus.source.f.z == z_out);

    // ********************
    // Register select
    // ********************
    always_comb begin
        reg_hot = '0;
        case (y)
            reg_b:   reg_hot[reg_b] = 1'b1;
            reg_c:   reg_hot[reg_c] = 1'b1;
            reg_d:   reg_hot[reg_d] = 1'b1;
            reg_e:   reg_hot[reg_e] = 1'b1;
            reg_h:   reg_hot[reg_h] = 1'b1;
            reg_l:   reg_hot[reg_l] = 1'b1;
            reg_f:   reg_hot[reg_f] = 1'b1;   // Flags only, or zero out.
            reg_a:   reg_hot[reg_a] = 1'b1;
            default: reg_hot = '0;
        endcase
    end

    assign in_r  = in_hit  ? reg_hot : '0;
    assign out_r = out_hit ? reg_hot : '0;

    assign done = in_hit | out_hit;

endmodule

// File: logic/xotr_decode_top.sv
`timescale 1ns/1ps
/* ED-prefix decode stage. Sequencer plus the three group decoders. */
module xotr_decode_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       ir_load,
    input  logic       ed_prefix,
    input  logic [7:0] ir,
    output logic       busy,
    output logic       set_cmr,
    output logic [3:0] ld_nn_dd,
    output logic [3:0] ld_dd_nn,
    output logic [3:0] adc_hl,
    output logic [3:0] sbc_hl,
    output logic [7:0] in_r,
    output logic [7:0] out_r,
    output logic       xotr_abort
);

    // Clear requests back to the sequencer.
    logic ld_done;
    logic alu16_done;
    logic io_done;

    xotr_bus_if i_bus (.clk(clk));

    xotr_sequencer i_sequencer (
        .clk        (clk),
        .reset      (reset),
        .ir_load    (ir_load),
        .ed_prefix  (ed_prefix),
        .ir         (ir),
        .ld_done    (ld_done),
        .alu16_done (alu16_done),
        .io_done    (io_done),
        .bus        (i_bus.seq),
        .busy       (busy),
        .xotr_abort (xotr_abort)
    );

    // ********************
    // Group decoders
    // ********************
    xotr_ld_nn_dd_decoder i_ld_decoder (
        .bus      (i_bus.dec),
        .done     (ld_done),
        .set_cmr  (set_cmr),
        .ld_nn_dd (ld_nn_dd),
        .ld_dd_nn (ld_dd_nn)
    );

    xotr_alu16_decoder i_alu16_decoder (
        .bus    (i_bus.dec),
        .done   (alu16_done),
        .adc_hl (adc_hl),
        .sbc_hl (sbc_hl)
    );

    xotr_io_decoder i_io_decoder (
        .bus   (i_bus.dec),
        .done  (io_done),
        .in_r  (in_r),
        .out_r (out_r)
    );

endmodule

// File: test/xotr_checker.sv
`timescale 1ns/1ps
/* Checker for the ED decode stage. Tracks the step timing of
   each accepted load and compares every output each cycle. */
module xotr_checker import xotr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ir_load,
    input  logic       ed_prefix,
    input  logic [7:0] ir,
    input  logic       busy,
    input  logic       set_cmr,
    input  logic [3:0] ld_nn_dd,
    input  logic [3:0] ld_dd_nn,
    input  logic [3:0] adc_hl,
    input  logic [3:0] sbc_hl,
    input  logic [7:0] in_r,
    input  logic [7:0] out_r,
    input  logic       xotr_abort,
    output int         error_count,
    output int         check_count
);

    int         errors = 0;
    int         checks = 0;
    logic       active = 1'b0;
    int         step = 0;
    logic [7:0] op;

    assign error_count = errors;
    assign check_count = checks;

    // Claiming step of a byte, last step when no group takes it.
    function automatic int fire_step(input logic [7:0] code);
        if (code[7:6] != 2'd1) return xpt_steps - 1;
        case (code[2:0])
            3'd3:       return ld_step;
            3'd2:       return alu16_step;
            3'd0, 3'd1: return io_step;
            default:    return xpt_steps - 1;
        endcase
    endfunction

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, got %h at %0t", name, exp, got, $time);
        end
    endtask

    // ********************
    // Cycle model
    // ********************
    always @(posedge clk) begin
        int         k;
        logic       fire;
        logic [7:0] pair_hot;
        logic [7:0] reg_hot;
        logic [7:0] e_ld;
        logic [7:0] e_alu;
        logic [7:0] e_io;
        if (reset) begin
            active <= 1'b0;
            step   <= 0;
        end else begin
            k        = fire_step(op);
            fire     = active && (step == k);
            pair_hot = 8'd1 << op[5:4];
            reg_hot  = 8'd1 << op[5:3];
            e_ld     = (fire && k == ld_step) ? pair_hot : 8'd0;
            e_alu    = (fire && k == alu16_step) ? pair_hot : 8'd0;
            e_io     = (fire && k == io_step) ? reg_hot : 8'd0;

            compare("busy", active, busy);
            compare("set_cmr", e_ld != 0, set_cmr);
            compare("ld_nn_dd", op[3] ? 8'd0 : e_ld, ld_nn_dd);   // q low stores.
            compare("ld_dd_nn", op[3] ? e_ld : 8'd0, ld_dd_nn);
            compare("sbc_hl", op[3] ? 8'd0 : e_alu, sbc_hl);
            compare("adc_hl", op[3] ? e_alu : 8'd0, adc_hl);
            compare("in_r", op[0] ? 8'd0 : e_io, in_r);
            compare("out_r", op[0] ? e_io : 8'd0, out_r);
            compare("xotr_abort", fire && k == xpt_steps - 1, xotr_abort);

            if (fire && !(set_cmr || ld_nn_dd || ld_dd_nn || adc_hl || sbc_hl
                          || in_r || out_r || xotr_abort)) begin
                errors++;
                $display("No pulse seen for opcode %h at step %0d", op, step);
            end

            // Loads while active are dropped.
            if (!active) begin
                if (ir_load && ed_prefix) begin
                    active <= 1'b1;
                    step   <= 0;
                    op     <= ir;
                end
            end else if (fire) begin
                active <= 1'b0;
                step   <= 0;
            end else begin
                step <= step + 1;
            end
        end
    end

endmodule

// File: test/xotr_tb.sv
`timescale 1ns/1ps
/* Testbench for the ED-prefix decode stage. Applies a table of
   second opcode bytes and measures how long busy stays high. */
module xotr_tb;

    typedef struct packed {
        logic [7:0] op;
        logic       ed;
        logic       second;     // Extra load while busy.
        logic [3:0] busy_len;   // Cycles of busy expected.
    } row_t;

    localparam int num_rows   = 42;
    localparam int busy_limit = 16;

    logic       clk;
    logic       reset;
    logic       ir_load;
    logic       ed_prefix;
    logic [7:0] ir;
    logic       busy;
    logic       set_cmr;
    logic [3:0] ld_nn_dd;
    logic [3:0] ld_dd_nn;
    logic [3:0] adc_hl;
    logic [3:0] sbc_hl;
    logic [7:0] in_r;
    logic [7:0] out_r;
    logic       xotr_abort;
    int         check_count;
    int         checker_errors;
    int         tb_errors;
    int         n;

    // ********************
    // Stimulus table
    // ********************
    row_t rows [num_rows] = '{
        // LD (nn),dd and LD dd,(nn).
        '{8'h43, 1'b1, 1'b0, 4'd1}, '{8'h4b, 1'b1, 1'b0, 4'd1}, '{8'h53, 1'b1, 1'b0, 4'd1},
        '{8'h5b, 1'b1, 1'b0, 4'd1}, '{8'h63, 1'b1, 1'b0, 4'd1}, '{8'h6b, 1'b1, 1'b0, 4'd1},
        '{8'h73, 1'b1, 1'b0, 4'd1}, '{8'h7b, 1'b1, 1'b0, 4'd1},
        // SBC and ADC HL,ss.
        '{8'h42, 1'b1, 1'b0, 4'd2}, '{8'h4a, 1'b1, 1'b0, 4'd2}, '{8'h52, 1'b1, 1'b0, 4'd2},
        '{8'h5a, 1'b1, 1'b0, 4'd2}, '{8'h62, 1'b1, 1'b0, 4'd2}, '{8'h6a, 1'b1, 1'b0, 4'd2},
        '{8'h72, 1'b1, 1'b0, 4'd2}, '{8'h7a, 1'b1, 1'b0, 4'd2},
        // IN r,(C) and OUT (C),r.
        '{8'h40, 1'b1, 1'b0, 4'd3}, '{8'h41, 1'b1, 1'b0, 4'd3}, '{8'h48, 1'b1, 1'b0, 4'd3},
        '{8'h49, 1'b1, 1'b0, 4'd3}, '{8'h50, 1'b1, 1'b0, 4'd3}, '{8'h51, 1'b1, 1'b0, 4'd3},
        '{8'h58, 1'b1, 1'b0, 4'd3}, '{8'h59, 1'b1, 1'b0, 4'd3}, '{8'h60, 1'b1, 1'b0, 4'd3},
        '{8'h61, 1'b1, 1'b0, 4'd3}, '{8'h68, 1'b1, 1'b0, 4'd3}, '{8'h69, 1'b1, 1'b0, 4'd3},
        '{8'h70, 1'b1, 1'b0, 4'd3}, '{8'h71, 1'b1, 1'b0, 4'd3}, '{8'h78, 1'b1, 1'b0, 4'd3},
        '{8'h79, 1'b1, 1'b0, 4'd3},
        // Unclaimed, then no prefix, then a load while busy.
        '{8'h44, 1'b1, 1'b0, 4'd5}, '{8'h45, 1'b1, 1'b0, 4'd5}, '{8'h47, 1'b1, 1'b0, 4'd5},
        '{8'h03, 1'b1, 1'b0, 4'd5}, '{8'ha0, 1'b1, 1'b0, 4'd5}, '{8'hc3, 1'b1, 1'b0, 4'd5},
        '{8'h43, 1'b0, 1'b0, 4'd0}, '{8'h78, 1'b0, 1'b0, 4'd0},
        '{8'h44, 1'b1, 1'b1, 4'd5}, '{8'h4b, 1'b1, 1'b1, 4'd1}
    };

    always #50 clk = ~clk;

    xotr_decode_top i_xotr_decode_top (.*);

    xotr_checker i_checker (
        .*,
        .error_count (checker_errors)
    );

    // ********************
    // Row driver
    // ********************
    task automatic apply_row(input row_t row);
        @(negedge clk);
        ir_load   = 1'b1;
        ed_prefix = row.ed;
        ir        = row.op;
        @(negedge clk);
        if (row.second) begin
            ir = 8'h4b;   // Must be ignored.
        end else begin
            ir_load   = 1'b0;
            ed_prefix = 1'b0;
        end
        n = 0;
        while (busy && n < busy_limit) begin
            n++;
            @(negedge clk);
            ir_load   = 1'b0;
            ed_prefix = 1'b0;
        end
        ir_load   = 1'b0;
        ed_prefix = 1'b0;
        if (busy) begin
            tb_errors++;
            $display("Timeout: busy stuck high after opcode %h", row.op);
        end else if (n != row.busy_len) begin
            tb_errors++;
            $display("FAIL busy_length: expected %h, got %h", row.busy_len, n[3:0]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        ir_load   = 1'b0;
        ed_prefix = 1'b0;
        ir        = 8'h00;
        tb_errors = 0;
        void'($urandom(32'h0ca5_68bf));
        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);   // Idle outputs checked here.

        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
            repeat ($urandom_range(3, 1)) @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
                 check_count, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
logic/xotr_pkg.sv
logic/xotr_bus_if.sv
logic/xotr_sequencer.sv
logic/xotr_ld_nn_dd_decoder.sv
logic/xotr_alu16_decoder.sv
logic/xotr_io_decoder.sv
logic/xotr_decode_top.sv
test/xotr_checker.sv
test/xotr_tb.sv

// File: Bender.yml
package:
  name: xotr_decode

sources:
  - logic/xotr_pkg.sv
  - logic/xotr_bus_if.sv
  - logic/xotr_sequencer.sv
  - logic/xotr_ld_nn_dd_decoder.sv
  - logic/xotr_alu16_decoder.sv
  - logic/xotr_io_decoder.sv
  - logic/xotr_decode_top.sv
  - target: test
    files:
      - test/xotr_checker.sv
      - test/xotr_tb.sv
